//--- hw/lock_defs.svh
`ifndef LOCK_DEFS_SVH
`define LOCK_DEFS_SVH

// Code format
`define LOCK_DIGITS          6
`define LOCK_DIGIT_W         4
`define LOCK_SLOTS           4

// Special keypad digit values
`define LOCK_DIGIT_TIMEOUT   4'hE    // Keypad gave up waiting for digits
`define LOCK_DIGIT_CANCEL    4'hB    // The # key
`define LOCK_DIGIT_BLANK     4'hF    // Unused digit, also marks an empty slot

// Timing in clock cycles, scaled down for simulation
`define LOCK_DEBOUNCE_CYCLES 4
`define LOCK_RELOCK_CYCLES   40
`define LOCK_BEEP_CYCLES     30
`define LOCK_LOCKOUT_CYCLES  60

// Failed entries allowed before the keypad locks out
`define LOCK_MAX_ATTEMPTS    5

`endif

//--- hw/lock_pkg.sv
`include "lock_defs.svh"

package lock_pkg;

    // Digit 0 is the first digit typed
    typedef logic [`LOCK_DIGITS-1:0][`LOCK_DIGIT_W-1:0] code_t;

    // Keypad entry, valid for a single cycle
    typedef struct packed {
        logic  valid;
        code_t code;
    } key_entry_t;

    // User code write port
    typedef struct packed {
        logic       valid;
        logic [1:0] slot;
        code_t      code;
    } code_wr_t;

    typedef struct packed {
        logic       locked;     // Latch engaged
        logic       keypad_en;
        logic       beep;
        logic       lockout;
        logic [2:0] fail_count;
    } lock_status_t;

    typedef enum logic [2:0] {
        INIT,       // Waiting for the door to close after reset
        LOCKED,
        CHECKING,   // Entry under comparison
        UNLATCHED,  // Closed but latch released
        OPEN
    } door_state_t;

endpackage

//--- hw/button_debounce.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module button_debounce (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    localparam int CNT_W = $clog2(`LOCK_DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_MAX  = CNT_W'(`LOCK_DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`LOCK_DEBOUNCE_CYCLES - 1);

    logic [CNT_W-1:0] hold_cnt;    // Cycles the button has been seen high

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_cnt <= '0;
            press    <= 1'b0;
        end else begin
            if (!button) begin
                hold_cnt <= '0;
            end else if (hold_cnt != HOLD_MAX) begin
                hold_cnt <= hold_cnt + 1'b1;    // Saturates, so one pulse per hold
            end

            // Single pulse on the last cycle of the required hold
            press <= button && (hold_cnt == HOLD_LAST);
        end
    end

endmodule

//--- hw/code_checker.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module code_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              store_en,
    input  lock_pkg::code_wr_t code_wr,
    input  logic              start,
    input  lock_pkg::code_t   entry_code,
    output logic              done,
    output logic              ok
);

    import lock_pkg::*;

    localparam int SLOT_W = $clog2(`LOCK_SLOTS);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`LOCK_SLOTS - 1);
    localparam code_t BLANK_CODE = {`LOCK_DIGITS{`LOCK_DIGIT_BLANK}};

    code_t codes [`LOCK_SLOTS];    // Stored user codes
    code_t entry_q;                // Entry under test, kept for the whole walk
    logic  busy;
    logic  [SLOT_W-1:0] slot;
    logic  hit;

    // Code storage, writes only allowed while the door is not locked
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LOCK_SLOTS; i++) begin
                codes[i] <= BLANK_CODE;
            end
        end else if (code_wr.valid && store_en) begin
            codes[code_wr.slot] <= code_wr.code;
        end
    end

    always_ff @(posedge clk) begin
        if (start) entry_q <= entry_code;
    end

    // Slot walk, one stored code per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (start) begin
            busy <= 1'b1;    // Restart also allowed on the done cycle
            slot <= '0;
        end else if (busy) begin
            if (done) begin
                busy <= 1'b0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // An empty slot must never unlock the door
    assign hit  = (codes[slot] == entry_q) && (codes[slot] != BLANK_CODE);
    assign done = busy && (hit || slot == SLOT_LAST);
    assign ok   = busy && hit;

endmodule

//--- hw/attempt_guard.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module attempt_guard (
    input  logic       clk,
    input  logic       rst,
    input  logic       fail,
    input  logic       pass,
    output logic       lockout,
    output logic [2:0] fail_count
);

    localparam int TMR_W = $clog2(`LOCK_LOCKOUT_CYCLES + 1);
    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`LOCK_LOCKOUT_CYCLES - 1);
    localparam logic [2:0] FAIL_LAST = 3'(`LOCK_MAX_ATTEMPTS - 1);

    logic [TMR_W-1:0] lock_tmr;    // Cycles spent in lockout

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fail_count <= '0;
            lockout    <= 1'b0;
            lock_tmr   <= '0;
        end else if (lockout) begin
            // Keypad is off, so only the countdown matters here
            if (lock_tmr == TMR_LAST) begin
                lockout    <= 1'b0;
                fail_count <= '0;
                lock_tmr   <= '0;
            end else begin
                lock_tmr <= lock_tmr + 1'b1;
            end
        end else if (pass) begin
            fail_count <= '0;
        end else if (fail) begin
            fail_count <= fail_count + 1'b1;
            if (fail_count == FAIL_LAST) begin
                lockout  <= 1'b1;    // Rises together with the final count
                lock_tmr <= '0;
            end
        end
    end

endmodule

//--- hw/lock_fsm.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module lock_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                sensor,
    input  logic                press,
    input  lock_pkg::key_entry_t entry,
    input  logic                lockout,
    input  logic                check_done,
    input  logic                check_ok,
    output logic                check_start,
    output lock_pkg::code_t     entry_code,
    output logic                fail,
    output logic                pass,
    output logic                store_en,
    output logic                locked,
    output logic                keypad_en,
    output logic                beep
);

    import lock_pkg::*;

    // Shared timer must reach the longer of the two limits
    localparam int TMR_MAX = (`LOCK_RELOCK_CYCLES > `LOCK_BEEP_CYCLES) ?
                             `LOCK_RELOCK_CYCLES : `LOCK_BEEP_CYCLES;
    localparam int TMR_W   = $clog2(TMR_MAX + 1);
    localparam logic [TMR_W-1:0] TMR_SAT     = TMR_W'(TMR_MAX);
    localparam logic [TMR_W-1:0] RELOCK_LAST = TMR_W'(`LOCK_RELOCK_CYCLES - 1);
    localparam logic [TMR_W-1:0] BEEP_AT     = TMR_W'(`LOCK_BEEP_CYCLES);

    door_state_t state, state_nxt;
    logic [TMR_W-1:0] timer;
    logic [`LOCK_DIGIT_W-1:0] first_digit;
    logic key_timeout;
    logic key_submit;
    logic beep_tmo;    // One cycle beep after a keypad timeout

    assign first_digit = entry.code[0];
    assign key_timeout = entry.valid && (first_digit == `LOCK_DIGIT_TIMEOUT);
    assign key_submit  = entry.valid &&
                         (first_digit != `LOCK_DIGIT_TIMEOUT) &&
                         (first_digit != `LOCK_DIGIT_CANCEL) &&
                         (first_digit != `LOCK_DIGIT_BLANK);

    assign keypad_en   = (state == LOCKED) && !lockout;
    assign locked      = (state == LOCKED) || (state == CHECKING);
    assign store_en    = !locked;

    // Checker latches the code in this same cycle
    assign check_start = keypad_en && !press && key_submit;
    assign entry_code  = entry.code;

    assign pass = (state == CHECKING) && check_done && check_ok;
    assign fail = (state == CHECKING) && check_done && !check_ok;

    always_comb begin
        state_nxt = state;
        case (state)
            INIT: begin
                if (!sensor) state_nxt = LOCKED;
            end
            LOCKED: begin
                // Button is ignored during lockout so the latch stays on
                if (press && !lockout) begin
                    state_nxt = UNLATCHED;
                end else if (check_start) begin
                    state_nxt = CHECKING;
                end
            end
            CHECKING: begin
                if (check_done) state_nxt = check_ok ? UNLATCHED : LOCKED;
            end
            UNLATCHED: begin
                if (sensor) begin
                    state_nxt = OPEN;
                end else if (press || timer == RELOCK_LAST) begin
                    state_nxt = LOCKED;    // Manual or automatic relock
                end
            end
            OPEN: begin
                if (!sensor) state_nxt = UNLATCHED;
            end
            default: state_nxt = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= INIT;
            timer    <= '0;
            beep_tmo <= 1'b0;
        end else begin
            state <= state_nxt;

            if (state_nxt != state) begin
                timer <= '0;    // Fresh count on every state entry
            end else if (timer != TMR_SAT) begin
                timer <= timer + 1'b1;
            end

            beep_tmo <= keypad_en && key_timeout;
        end
    end

    // Open-door warning stops as soon as the contact closes
    assign beep = beep_tmo || ((state == OPEN) && sensor && (timer >= BEEP_AT));

endmodule

//--- hw/door_lock_top.sv
`timescale 1ns/1ns

module door_lock_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sensor,
    input  logic                  inner_button,
    input  lock_pkg::key_entry_t  entry,
    input  lock_pkg::code_wr_t    code_wr,
    output lock_pkg::lock_status_t status
);

    import lock_pkg::*;

    logic       press;
    logic       check_start;
    logic       check_done;
    logic       check_ok;
    code_t      entry_code;
    logic       fail;
    logic       pass;
    logic       store_en;
    logic       lockout;
    logic [2:0] fail_count;
    logic       locked;
    logic       keypad_en;
    logic       beep;

    button_debounce u_button_debounce (
        .clk    (clk),
        .rst    (rst),
        .button (inner_button),
        .press  (press)
    );

    code_checker u_code_checker (
        .clk        (clk),
        .rst        (rst),
        .store_en   (store_en),
        .code_wr    (code_wr),
        .start      (check_start),
        .entry_code (entry_code),
        .done       (check_done),
        .ok         (check_ok)
    );

    attempt_guard u_attempt_guard (
        .clk        (clk),
        .rst        (rst),
        .fail       (fail),
        .pass       (pass),
        .lockout    (lockout),
        .fail_count (fail_count)
    );

    lock_fsm u_lock_fsm (
        .clk         (clk),
        .rst         (rst),
        .sensor      (sensor),
        .press       (press),
        .entry       (entry),
        .lockout     (lockout),
        .check_done  (check_done),
        .check_ok    (check_ok),
        .check_start (check_start),
        .entry_code  (entry_code),
        .fail        (fail),
        .pass        (pass),
        .store_en    (store_en),
        .locked      (locked),
        .keypad_en   (keypad_en),
        .beep        (beep)
    );

    assign status = '{locked:     locked,
                      keypad_en:  keypad_en,
                      beep:       beep,
                      lockout:    lockout,
                      fail_count: fail_count};

endmodule

//--- verif/door_lock_assertions.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module door_lock_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   sensor,
    input lock_pkg::lock_status_t status
);

    int unsigned fire_cnt = 0;    // Read by the testbench at the end of the run

    // Keypad only works on a latched door
    keypad_needs_latch: assert property (@(posedge clk) disable iff (rst)
        status.keypad_en |-> status.locked)
        else begin
            $error("keypad enabled while the door is unlatched");
            fire_cnt++;
        end

    lockout_needs_latch: assert property (@(posedge clk) disable iff (rst)
        status.lockout |-> status.locked)
        else begin
            $error("lockout active while the door is unlatched");
            fire_cnt++;
        end

    // A closed, unlatched door has no reason to beep
    no_beep_when_closed: assert property (@(posedge clk) disable iff (rst)
        !(status.beep && !sensor && !status.locked))
        else begin
            $error("beep on a closed, unlatched door");
            fire_cnt++;
        end

    fail_count_limit: assert property (@(posedge clk) disable iff (rst)
        status.fail_count <= `LOCK_MAX_ATTEMPTS)
        else begin
            $error("fail count above the attempt limit");
            fire_cnt++;
        end

endmodule

bind door_lock_top door_lock_assertions u_door_lock_assertions (
    .clk    (clk),
    .rst    (rst),
    .sensor (sensor),
    .status (status)
);

//--- verif/door_lock_tb.sv
`timescale 1ns/1ns
`include "lock_defs.svh"

module door_lock_tb;

    import lock_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    // Five relock waits, one lockout, one open-door span plus margin for entries and presses
    localparam int RUN_LIMIT = RESET_CYCLES + 5 * `LOCK_RELOCK_CYCLES + `LOCK_LOCKOUT_CYCLES +
                               2 * `LOCK_BEEP_CYCLES + 300;
    localparam int S_INIT      = 0;
    localparam int S_LOCKED    = 1;
    localparam int S_CHECKING  = 2;
    localparam int S_UNLATCHED = 3;
    localparam int S_OPEN      = 4;
    localparam code_t BLANK = {`LOCK_DIGITS{`LOCK_DIGIT_BLANK}};

    logic         clk;
    logic         rst;
    logic         sensor;
    logic         inner_button;
    key_entry_t   entry;
    code_wr_t     code_wr;
    lock_status_t status;

    int seed;
    int cycle_cnt = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int errors_before = 0;

    // Reference model of the lock
    int    m_state;
    int    m_timer;      // Cycles since the current state was entered
    int    m_hold;       // Consecutive cycles with the button high
    bit    m_press;
    bit    m_beep_tmo;
    bit    m_lockout;
    int    m_lock_cnt;
    int    m_fails;
    int    m_done_at;    // Cycle in CHECKING that ends the compare
    bit    m_ok;
    code_t m_codes [`LOCK_SLOTS];

    door_lock_top u_door_lock_top (
        .clk          (clk),
        .rst          (rst),
        .sensor       (sensor),
        .inner_button (inner_button),
        .entry        (entry),
        .code_wr      (code_wr),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int find_slot(code_t c);
        for (int i = 0; i < `LOCK_SLOTS; i++) begin
            if (m_codes[i] == c && c != BLANK) return i;
        end
        return -1;
    endfunction

    function automatic lock_status_t expected_status();
        lock_status_t e;
        e.locked     = (m_state == S_LOCKED) || (m_state == S_CHECKING);
        e.keypad_en  = (m_state == S_LOCKED) && !m_lockout;
        e.beep       = m_beep_tmo ||
                       (m_state == S_OPEN && sensor && m_timer >= `LOCK_BEEP_CYCLES);
        e.lockout    = m_lockout;
        e.fail_count = 3'(m_fails);
        return e;
    endfunction

    task automatic model_step();
        int  nxt;
        bit  keypad;
        bit  start;
        bit  done;
        logic [`LOCK_DIGIT_W-1:0] d0;
        d0     = entry.code[0];
        keypad = (m_state == S_LOCKED) && !m_lockout;
        start  = keypad && !m_press && entry.valid && d0 != `LOCK_DIGIT_TIMEOUT &&
                 d0 != `LOCK_DIGIT_CANCEL && d0 != `LOCK_DIGIT_BLANK;
        done   = (m_state == S_CHECKING) && (m_timer == m_done_at);
        nxt    = m_state;
        case (m_state)
            S_INIT:      if (!sensor) nxt = S_LOCKED;
            S_LOCKED: begin
                if (m_press && !m_lockout) begin
                    nxt = S_UNLATCHED;
                end else if (start) begin
                    nxt       = S_CHECKING;
                    m_ok      = find_slot(entry.code) >= 0;
                    m_done_at = m_ok ? find_slot(entry.code) : `LOCK_SLOTS - 1;
                end
            end
            S_CHECKING:  if (done) nxt = m_ok ? S_UNLATCHED : S_LOCKED;
            S_UNLATCHED: begin
                if (sensor) nxt = S_OPEN;
                else if (m_press || m_timer == `LOCK_RELOCK_CYCLES - 1) nxt = S_LOCKED;
            end
            default:     if (!sensor) nxt = S_UNLATCHED;
        endcase
        if (m_lockout) begin
            m_lock_cnt++;
            if (m_lock_cnt == `LOCK_LOCKOUT_CYCLES) begin
                m_lockout = 1'b0;
                m_fails   = 0;
            end
        end else if (done && m_ok) begin
            m_fails = 0;
        end else if (done) begin
            m_fails++;
            m_lockout  = (m_fails == `LOCK_MAX_ATTEMPTS);
            m_lock_cnt = 0;
        end
        if (code_wr.valid && (m_state == S_UNLATCHED || m_state == S_OPEN || m_state == S_INIT))
            m_codes[code_wr.slot] = code_wr.code;
        m_beep_tmo = keypad && entry.valid && d0 == `LOCK_DIGIT_TIMEOUT;
        m_hold     = inner_button ? m_hold + 1 : 0;
        m_press    = (m_hold == `LOCK_DEBOUNCE_CYCLES);
        m_timer    = (nxt != m_state) ? 0 : m_timer + 1;
        m_state    = nxt;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_state    = S_INIT;
            m_timer    = 0;
            m_hold     = 0;
            m_press    = 1'b0;
            m_beep_tmo = 1'b0;
            m_lockout  = 1'b0;
            m_lock_cnt = 0;
            m_fails    = 0;
            m_done_at  = 0;
            m_ok       = 1'b0;
            foreach (m_codes[i]) m_codes[i] = BLANK;
        end else begin
            model_step();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= RUN_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_cond(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    // Outputs are stable at the falling edge, before new inputs go out
    task automatic next_cycle();
        lock_status_t exp;
        @(negedge clk);
        exp = expected_status();
        check_cond(status === exp,
                   $sformatf("status %b, expected %b", status, exp));
    endtask

    task automatic hold_button(input int n);
        inner_button = 1'b1;
        repeat (n) next_cycle();
        inner_button = 1'b0;
    endtask

    task automatic wait_door(input bit want_locked, input int limit);
        int n;
        n = 0;
        while (status.locked !== want_locked && n < limit) begin
            next_cycle();
            n++;
        end
        check_cond(status.locked === want_locked, "door did not reach the expected latch state");
    endtask

    task automatic submit_code(input code_t c);
        int n;
        entry.valid = 1'b1;
        entry.code  = c;
        next_cycle();
        entry.valid = 1'b0;
        n = 0;
        while (m_state == S_CHECKING && n < `LOCK_SLOTS + 2) begin
            next_cycle();
            n++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_before;
        $display("%-14s %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
        tests_run++;
        errors_before = errors;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic code_t random_code();
        code_t c;
        for (int i = 0; i < `LOCK_DIGITS; i++) c[i] = 4'(rand_range(0, 9));
        return c;
    endfunction

    function automatic code_t wrong_code();
        code_t c;
        c = random_code();
        while (find_slot(c) >= 0) c = random_code();
        return c;
    endfunction

    initial begin
        code_t wr_code;
        logic [1:0] wr_slot;
        int n;
        int open_len;
        int beeps;
        seed         = 99574;
        rst          = 1'b1;
        sensor       = 1'b1;
        inner_button = 1'b0;
        entry        = '0;
        code_wr      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        next_cycle();
        next_cycle();
        check_cond(status === '0, "outputs not low after reset with the door open");
        sensor = 1'b0;
        next_cycle();
        check_cond(status.locked && status.keypad_en, "door did not lock after closing");
        end_test("reset_startup");

        hold_button(`LOCK_DEBOUNCE_CYCLES);
        wait_door(1'b0, 3);
        for (int i = 0; i < `LOCK_SLOTS; i++) begin
            wr_code       = random_code();
            wr_slot       = 2'($random(seed));
            code_wr.valid = 1'b1;
            code_wr.slot  = wr_slot;
            code_wr.code  = wr_code;
            next_cycle();
        end
        code_wr.valid = 1'b0;
        wait_door(1'b1, `LOCK_RELOCK_CYCLES + 5);
        code_wr.valid = 1'b1;    // Overwrite attempt on a locked door
        code_wr.code  = wrong_code();
        next_cycle();
        code_wr.valid = 1'b0;
        submit_code(wrong_code());
        check_cond(status.fail_count == 1, "wrong entry did not raise the fail count");
        entry.valid = 1'b1;
        entry.code  = wr_code;
        next_cycle();
        entry.valid = 1'b0;
        n = 0;
        while (status.locked && n < 8) begin
            next_cycle();
            n++;
        end
        check_cond(!status.locked && n >= 1 && n <= `LOCK_SLOTS,
                   $sformatf("stored code took %0d cycles to unlatch", n));
        check_cond(status.fail_count == 0, "correct entry did not clear the fail count");
        wait_door(1'b1, `LOCK_RELOCK_CYCLES + 5);
        end_test("code_entry");

        for (int i = 0; i < `LOCK_MAX_ATTEMPTS; i++) submit_code(wrong_code());
        check_cond(status.lockout && status.fail_count == `LOCK_MAX_ATTEMPTS,
                   "no lockout after the last failed entry");
        n = 0;
        while (status.lockout && n < `LOCK_LOCKOUT_CYCLES + 5) begin
            entry.valid = (n == 10) || (n == 20);    // Right code, ignored during lockout
            entry.code  = wr_code;
            next_cycle();
            n++;
        end
        entry.valid = 1'b0;
        check_cond(n == `LOCK_LOCKOUT_CYCLES, $sformatf("lockout lasted %0d cycles", n));
        check_cond(status.fail_count == 0 && status.locked, "fail count not cleared after lockout");
        end_test("lockout");

        hold_button(rand_range(1, `LOCK_DEBOUNCE_CYCLES - 1));
        repeat (`LOCK_DEBOUNCE_CYCLES + 2) next_cycle();
        check_cond(status.locked, "short press unlatched the door");
        hold_button(rand_range(`LOCK_DEBOUNCE_CYCLES, `LOCK_DEBOUNCE_CYCLES + 4));
        repeat (2) next_cycle();
        check_cond(!status.locked, "long press did not unlatch the door");
        hold_button(rand_range(`LOCK_DEBOUNCE_CYCLES, `LOCK_DEBOUNCE_CYCLES + 4));
        repeat (2) next_cycle();
        check_cond(status.locked, "second long press did not relock the door");
        end_test("inside_button");

        hold_button(`LOCK_DEBOUNCE_CYCLES);
        wait_door(1'b0, 3);
        n = 0;
        while (!status.locked && n < `LOCK_RELOCK_CYCLES + 5) begin
            next_cycle();
            n++;
        end
        check_cond(n == `LOCK_RELOCK_CYCLES, $sformatf("automatic relock after %0d cycles", n));
        hold_button(`LOCK_DEBOUNCE_CYCLES);
        wait_door(1'b0, 3);
        sensor   = 1'b1;
        open_len = rand_range(`LOCK_BEEP_CYCLES + 5, `LOCK_BEEP_CYCLES + 15);
        beeps    = 0;
        repeat (open_len) begin
            next_cycle();
            if (status.beep) beeps++;
        end
        sensor = 1'b0;
        next_cycle();
        check_cond(beeps == open_len - `LOCK_BEEP_CYCLES && !status.beep,
                   $sformatf("open door beeped %0d cycles out of %0d", beeps, open_len));
        wait_door(1'b1, `LOCK_RELOCK_CYCLES + 5);
        entry.valid = 1'b1;
        entry.code  = random_code();
        entry.code[0] = `LOCK_DIGIT_TIMEOUT;
        next_cycle();
        entry.valid = 1'b0;
        beeps = status.beep ? 1 : 0;
        repeat (3) begin
            next_cycle();
            if (status.beep) beeps++;
        end
        check_cond(beeps == 1, $sformatf("keypad timeout gave %0d beep cycles", beeps));
        end_test("relock_beep");

        if (u_door_lock_top.u_door_lock_assertions.fire_cnt != 0) begin
            $display("Concurrent assertions fired %0d times",
                     u_door_lock_top.u_door_lock_assertions.fire_cnt);
            errors += u_door_lock_top.u_door_lock_assertions.fire_cnt;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/lock_pkg.sv
hw/button_debounce.sv
hw/code_checker.sv
hw/attempt_guard.sv
hw/lock_fsm.sv
hw/door_lock_top.sv
verif/door_lock_assertions.sv
verif/door_lock_tb.sv
